// ==== Bender.yml ====
package:
  name: conv_55

sources:
  - conv_pkg.sv
  - feature_ram.sv
  - kernel_store.sv
  - conv_ctrl.sv
  - window_shift.sv
  - conv_mac.sv
  - relu_quant.sv
  - conv_55_top.sv
  - target: test
    files:
      - conv_55_props.sv
      - tb_conv_55.sv

// ==== conv_55_props.sv ====
`timescale 1ns/100ps

module conv_55_props import conv_pkg::*; (
    input logic             clk,
    input logic             reset,
    input logic             start,
    input logic             pix_valid,
    input logic [PIX_W-1:0] pix_out,
    input logic             done
);

    logic started;                  // a start has been seen since reset
    int   fails = 0;                // failed assertion count

    always_ff @(posedge clk)
    begin
        if (reset)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    // outputs cleared by the reset edge
    a_reset_quiet: assert property (@(posedge clk) reset |=> !pix_valid && !done)
        else
        begin
            fails++;
            $error("pix_valid or done high after a reset cycle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else
        begin
            fails++;
            $error("done held for more than one cycle");
        end

    a_pix_range: assert property (@(posedge clk) disable iff (reset)
                                  pix_valid |-> pix_out <= PIX_MAX)
        else
        begin
            fails++;
            $error("pix_out above 127");
        end

    a_no_early_strobe: assert property (@(posedge clk) disable iff (reset)
                                        $rose(pix_valid) |-> started)
        else
        begin
            fails++;
            $error("pix_valid rose before any start");
        end

endmodule

bind conv_55_top conv_55_props u_props (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .pix_valid (pix_valid),
    .pix_out   (pix_out),
    .done      (done)
);

// ==== conv_55_top.sv ====
`timescale 1ns/100ps

module conv_55_top import conv_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               feat_we,
    input  logic [FEAT_AW-1:0] feat_addr,      // row * 16 + col
    input  pix_t               feat_data,
    input  logic               kernel_we,
    input  logic [KADDR_W-1:0] kernel_addr,
    input  logic [BIAS_W-1:0]  kernel_data,
    output logic               pix_valid,
    output logic [PIX_W-1:0]   pix_out,
    output logic               done
);

    col_fetch_t               fetch;           // issue, cycle 0
    col_fetch_t               fetch_q;         // aligned with ram data, cycle 1
    logic [FEAT_AW-1:0]       row_base;
    pix_col_t                 ram_col;
    window_t                  win;             // cycle 2
    kernel_t                  weights;
    logic signed [BIAS_W-1:0] bias;
    acc_t                     acc;             // cycle 5
    logic                     acc_last;        // with pix_valid, cycle 6

    conv_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .acc_last (acc_last),
        .fetch    (fetch),
        .row_base (row_base),
        .done     (done)
    );

    feature_ram u_feature_ram (
        .clk       (clk),
        .we        (feat_we),
        .waddr     (feat_addr),
        .wdata     (feat_data),
        .fetch_in  (fetch),
        .row_base  (row_base),
        .col       (ram_col),
        .fetch_out (fetch_q)
    );

    kernel_store u_kernel_store (
        .clk     (clk),
        .reset   (reset),
        .we      (kernel_we),
        .addr    (kernel_addr),
        .data    (kernel_data),
        .weights (weights),
        .bias    (bias)
    );

    window_shift u_window (
        .clk   (clk),
        .reset (reset),
        .col   (ram_col),
        .fetch (fetch_q),
        .win   (win)
    );

    conv_mac u_mac (
        .clk     (clk),
        .reset   (reset),
        .win     (win),
        .weights (weights),
        .bias    (bias),
        .acc     (acc)
    );

    relu_quant u_relu (
        .clk       (clk),
        .reset     (reset),
        .acc       (acc),
        .pix_valid (pix_valid),
        .pix_out   (pix_out),
        .acc_last  (acc_last)
    );

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/100ps

module conv_ctrl import conv_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               acc_last,
    output col_fetch_t         fetch,
    output logic [FEAT_AW-1:0] row_base,
    output logic               done
);

    conv_state_e      state;
    logic [ROW_W-1:0] row_cnt;          // output row, top row of the window
    logic [COL_W-1:0] col_cnt;          // input column being fetched
    logic             row_end;
    logic             frame_end;

    assign row_end   = (col_cnt == COL_W'(IMG_W - 1));
    assign frame_end = row_end && (row_cnt == ROW_W'(OUT_H - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= st_idle;
            row_cnt <= '0;
            col_cnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                st_idle:
                begin
                    row_cnt <= '0;
                    col_cnt <= '0;
                    if (start)
                        state <= st_run;
                end

                st_run:                 // start has no effect here
                begin
                    col_cnt <= col_cnt + 1'b1;       // wraps 15 -> 0
                    if (row_end)
                        row_cnt <= row_cnt + 1'b1;
                    if (frame_end)
                        state <= st_drain;
                end

                st_drain:
                begin
                    // pipeline still holds up to six columns
                    if (acc_last)
                    begin
                        done  <= 1'b1;  // one cycle after the final strobe
                        state <= st_idle;
                    end
                end

                default:
                    state <= st_idle;
            endcase
        end
    end

    // one column read per run cycle
    always_comb
    begin
        fetch = '0;
        if (state == st_run)
        begin
            fetch.valid = 1'b1;
            fetch.full  = (col_cnt >= COL_W'(IMG_W - OUT_W));   // columns 4..15
            fetch.last  = frame_end;
            fetch.col   = col_cnt;
        end
    end

    // first pixel of the window's top row
    assign row_base = FEAT_AW'(row_cnt * IMG_W);

endmodule

// ==== conv_mac.sv ====
`timescale 1ns/100ps

module conv_mac import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  window_t                  win,
    input  kernel_t                  weights,
    input  logic signed [BIAS_W-1:0] bias,
    output acc_t                     acc
);

    logic signed [2*PIX_W-1:0] prod [KTAPS];    // stage 1
    logic signed [ACC_W-1:0]   rsum [KSIZE];    // stage 2, one per kernel row
    logic signed [ACC_W-1:0]   total;           // stage 3
    logic [2:0]                vld_q;           // valid per stage
    logic [2:0]                lst_q;           // last per stage

    // stage 1, all 25 products at once
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < KTAPS; i++)
            prod[i] <= win.pix[i] * weights[i];
    end

    // stage 2, row sums of five products
    always_ff @(posedge clk)
    begin : tree_rows
        logic signed [ACC_W-1:0] s;
        for (int r = 0; r < KSIZE; r++)
        begin
            s = '0;
            for (int c = 0; c < KSIZE; c++)
                s = s + prod[r*KSIZE + c];
            rsum[r] <= s;
        end
    end

    // stage 3, row sums plus bias
    always_ff @(posedge clk)
    begin : tree_total
        logic signed [ACC_W-1:0] s;
        s = bias;                                // sign extended
        for (int r = 0; r < KSIZE; r++)
            s = s + rsum[r];
        total <= s;
    end

    // flags follow the data down the pipe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vld_q <= '0;
            lst_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[1:0], win.valid};
            lst_q <= {lst_q[1:0], win.valid && win.last};
        end
    end

    assign acc.valid = vld_q[2];
    assign acc.last  = lst_q[2];
    assign acc.sum   = total;

endmodule

// ==== conv_pkg.sv ====
package conv_pkg;

    // pixel and weight format
    localparam int PIX_W   = 8;                   // signed pixels and weights
    localparam int PIX_MAX = 2**(PIX_W-1) - 1;    // saturation ceiling, 127

    // kernel geometry
    localparam int KSIZE = 5;
    localparam int KTAPS = KSIZE * KSIZE;         // 25 weights per kernel

    // input map and valid output map
    localparam int IMG_W = 16;
    localparam int IMG_H = 16;
    localparam int OUT_W = IMG_W - KSIZE + 1;     // 12 output columns
    localparam int OUT_H = IMG_H - KSIZE + 1;     // 12 output rows

    // address and counter widths
    localparam int FEAT_AW = $clog2(IMG_W * IMG_H);   // row * 16 + col
    localparam int COL_W   = $clog2(IMG_W);
    localparam int ROW_W   = $clog2(OUT_H);

    // arithmetic
    localparam int BIAS_W = 16;
    localparam int ACC_W  = 24;                   // 25 products plus bias fit with room
    localparam int QSHIFT = 8;                    // fixed-8 scaling

    // kernel store map, weights row-major then the bias
    localparam int KADDR_W   = 5;
    localparam int BIAS_ADDR = KTAPS;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } conv_state_e;

    typedef logic signed [PIX_W-1:0] pix_t;

    typedef pix_t [KSIZE-1:0] pix_col_t;          // index 0 is the top row
    typedef pix_t [KTAPS-1:0] kernel_t;           // index r*KSIZE + c

    typedef struct packed {
        logic             valid;
        logic             full;                   // window holds a complete 5x5 patch
        logic             last;                   // final column of the frame
        logic [COL_W-1:0] col;
    } col_fetch_t;

    typedef struct packed {
        logic    valid;
        logic    last;
        kernel_t pix;                             // row-major, column 4 newest
    } window_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic signed [ACC_W-1:0] sum;
    } acc_t;

endpackage

// ==== feature_ram.sv ====
`timescale 1ns/100ps

module feature_ram import conv_pkg::*; (
    input  logic               clk,
    input  logic               we,
    input  logic [FEAT_AW-1:0] waddr,
    input  pix_t               wdata,
    input  col_fetch_t         fetch_in,
    input  logic [FEAT_AW-1:0] row_base,
    output pix_col_t           col,
    output col_fetch_t         fetch_out
);

    // one copy of the full map per kernel row, all written together
    for (genvar k = 0; k < KSIZE; k++)
    begin : g_bank
        pix_t               mem [IMG_W*IMG_H];
        pix_t               rd_q;
        logic [FEAT_AW-1:0] raddr;

        // k rows below the window top, same column
        assign raddr = row_base + FEAT_AW'(k * IMG_W) + FEAT_AW'(fetch_in.col);

        always_ff @(posedge clk)
        begin
            if (we)
                mem[waddr] <= wdata;
            rd_q <= mem[raddr];          // registered read
        end

        assign col[k] = rd_q;
    end

    // keep the fetch tag lined up with the read data
    always_ff @(posedge clk)
        fetch_out <= fetch_in;

endmodule

// ==== kernel_store.sv ====
`timescale 1ns/100ps

module kernel_store import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [KADDR_W-1:0]       addr,
    input  logic [BIAS_W-1:0]        data,
    output kernel_t                  weights,
    output logic signed [BIAS_W-1:0] bias
);

    logic wr_weight;
    logic wr_bias;

    // address decode, 0..24 weights, 25 bias, rest ignored
    assign wr_weight = we && (addr < KADDR_W'(KTAPS));
    assign wr_bias   = we && (addr == KADDR_W'(BIAS_ADDR));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            weights <= '0;
            bias    <= '0;
        end
        else
        begin
            if (wr_weight)
                weights[addr] <= data[PIX_W-1:0];   // low byte only
            if (wr_bias)
                bias <= data;                       // full 16 bits
        end
    end

    // held levels go straight to the MAC in parallel

endmodule

// ==== relu_quant.sv ====
`timescale 1ns/100ps

module relu_quant import conv_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  acc_t             acc,
    output logic             pix_valid,
    output logic [PIX_W-1:0] pix_out,
    output logic             acc_last
);

    logic signed [ACC_W-1:0] scaled;
    logic [PIX_W-1:0]        clipped;

    always_comb
    begin
        scaled = acc.sum >>> QSHIFT;                 // arithmetic, keeps the sign
        if (scaled < 0)
            clipped = '0;                            // relu
        else if (scaled > PIX_MAX)
            clipped = PIX_W'(PIX_MAX);               // clip at 127
        else
            clipped = scaled[PIX_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pix_valid <= 1'b0;
            pix_out   <= '0;
            acc_last  <= 1'b0;
        end
        else
        begin
            pix_valid <= acc.valid;
            pix_out   <= clipped;
            acc_last  <= acc.valid && acc.last;      // tells the controller to finish
        end
    end

endmodule

// ==== tb_conv_55.sv ====
`timescale 1ns/100ps

module tb_conv_55 import conv_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_FRAMES  = 5;
    localparam int FRAME_CYC   = IMG_W*IMG_H + KTAPS + 1 + 200;   // loads, bias, run
    localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_CYC * CLK_PERIOD + 100 * CLK_PERIOD;

    logic               clk;
    logic               reset;
    logic               start;
    logic               feat_we;
    logic [FEAT_AW-1:0] feat_addr;
    pix_t               feat_data;
    logic               kernel_we;
    logic [KADDR_W-1:0] kernel_addr;
    logic [BIAS_W-1:0]  kernel_data;
    logic               pix_valid;
    logic [PIX_W-1:0]   pix_out;
    logic               done;

    integer seed;
    int     errors;
    int     checks;
    int     img [IMG_W*IMG_H];      // reference copy of the feature map
    int     wts [KTAPS];            // row-major weights
    int     bias_v;
    int     expected_q [$];         // model outputs in raster order
    int     strobes;                // pix_valid count in the current frame
    int     cyc;
    int     last_strobe_cyc;
    logic   done_seen;

    conv_55_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .feat_we     (feat_we),
        .feat_addr   (feat_addr),
        .feat_data   (feat_data),
        .kernel_we   (kernel_we),
        .kernel_addr (kernel_addr),
        .kernel_data (kernel_data),
        .pix_valid   (pix_valid),
        .pix_out     (pix_out),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // hard stop in case done never arrives
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'({$random(seed)} % span);
    endfunction

    // bias plus 5x5 dot product, then shift, relu and clip
    function automatic int model_pixel(input int orow, input int ocol);
        int sum;
        int q;
        sum = bias_v;
        for (int r = 0; r < KSIZE; r++)
            for (int c = 0; c < KSIZE; c++)
                sum += img[(orow + r) * IMG_W + ocol + c] * wts[r * KSIZE + c];
        q = sum >>> QSHIFT;
        if (q < 0)
            q = 0;
        else if (q > PIX_MAX)
            q = PIX_MAX;
        return q;
    endfunction

    task automatic fill_image(input int lo, input int hi);
        for (int i = 0; i < IMG_W*IMG_H; i++)
            img[i] = rand_range(lo, hi);
    endtask

    task automatic fill_kernel(input int wlo, input int whi, input int blo, input int bhi);
        for (int i = 0; i < KTAPS; i++)
            wts[i] = rand_range(wlo, whi);
        bias_v = rand_range(blo, bhi);
    endtask

    task automatic load_image();
        for (int i = 0; i < IMG_W*IMG_H; i++)
        begin
            @(posedge clk);
            #2;
            feat_we   = 1'b1;
            feat_addr = FEAT_AW'(i);        // row * 16 + col
            feat_data = pix_t'(img[i]);
        end
        @(posedge clk);
        #2;
        feat_we = 1'b0;
    endtask

    task automatic load_kernel();
        for (int i = 0; i <= KTAPS; i++)
        begin
            @(posedge clk);
            #2;
            kernel_we   = 1'b1;
            kernel_addr = KADDR_W'(i);
            // last write is the bias at address 25
            kernel_data = (i == BIAS_ADDR) ? BIAS_W'(bias_v) : BIAS_W'(wts[i]);
        end
        @(posedge clk);
        #2;
        kernel_we = 1'b0;
    endtask

    // one frame, optionally with a stray start in the middle of the run
    task automatic run_frame(input int frame, input bit extra_start);
        expected_q.delete();
        for (int r = 0; r < OUT_H; r++)
            for (int c = 0; c < OUT_W; c++)
                expected_q.push_back(model_pixel(r, c));
        strobes         = 0;
        done_seen       = 1'b0;
        last_strobe_cyc = -10;
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (extra_start)
        begin
            repeat (50) @(posedge clk);
            #2;
            start = 1'b1;                   // engine is in run here
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        wait (done_seen);
        repeat (20) @(posedge clk);         // room for a spurious second frame to show
        if (strobes != OUT_W*OUT_H)
        begin
            errors++;
            $display("frame %0d produced %0d pix_valid strobes instead of %0d",
                     frame, strobes, OUT_W*OUT_H);
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk)
    begin
        cyc++;
        if (!reset && pix_valid)
        begin
            strobes++;
            last_strobe_cyc = cyc;
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("pix_valid strobe at %0t ns when no output was expected", $time);
            end
            else
                check_value("pix_out", expected_q.pop_front(), int'(pix_out));
        end
        if (!reset && done)
        begin
            done_seen = 1'b1;
            check_value("done cycle", last_strobe_cyc + 1, cyc);   // right after the last strobe
            check_value("strobes at done", OUT_W*OUT_H, strobes);  // no early finish
        end
    end

    initial
    begin
        seed            = 32'h6259;
        errors          = 0;
        checks          = 0;
        cyc             = 0;
        strobes         = 0;
        last_strobe_cyc = 0;
        done_seen       = 1'b0;
        reset           = 1'b1;
        start           = 1'b0;
        feat_we         = 1'b0;
        feat_addr       = '0;
        feat_data       = '0;
        kernel_we       = 1'b0;
        kernel_addr     = '0;
        kernel_data     = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // random map, small weights
        fill_image(-128, 127);
        fill_kernel(-16, 15, -2048, 2047);
        load_image();
        load_kernel();
        run_frame(1, 1'b0);

        // negative kernel on a positive map, all zero after relu
        fill_image(0, 127);
        fill_kernel(-128, -1, -512, 0);
        load_image();
        load_kernel();
        run_frame(2, 1'b0);

        // largest pixels and weights, clipped to 127
        fill_image(127, 127);
        fill_kernel(127, 127, 0, 1000);
        load_image();
        load_kernel();
        run_frame(3, 1'b0);

        // start repeated while running
        fill_image(-128, 127);
        fill_kernel(-16, 15, -2048, 2047);
        load_image();
        load_kernel();
        run_frame(4, 1'b1);

        // new kernel only, map kept from the last frame
        fill_kernel(-32, 31, -4096, 4095);
        load_kernel();
        run_frame(5, 1'b0);

        errors += u_dut.u_props.fails;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, u_dut.u_props.fails);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
conv_pkg.sv
feature_ram.sv
kernel_store.sv
conv_ctrl.sv
window_shift.sv
conv_mac.sv
relu_quant.sv
conv_55_top.sv
conv_55_props.sv
tb_conv_55.sv

// ==== window_shift.sv ====
`timescale 1ns/100ps

module window_shift import conv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  pix_col_t   col,
    input  col_fetch_t fetch,
    output window_t    win
);

    kernel_t taps;                 // row-major 5x5 patch
    logic    win_valid;
    logic    win_last;

    // new column enters at the right, older columns move left
    always_ff @(posedge clk)
    begin
        if (fetch.valid)
        begin
            for (int r = 0; r < KSIZE; r++)
            begin
                for (int c = 0; c < KSIZE - 1; c++)
                    taps[r*KSIZE + c] <= taps[r*KSIZE + c + 1];
                taps[r*KSIZE + KSIZE - 1] <= col[r];
            end
        end
    end

    // flags for the patch just formed
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end
        else
        begin
            // columns 0..3 only prime the window
            win_valid <= fetch.valid && fetch.full;
            win_last  <= fetch.valid && fetch.last;
        end
    end

    assign win.valid = win_valid;
    assign win.last  = win_last;
    assign win.pix   = taps;

endmodule
